//--- rv_exec_pkg.sv
`default_nettype none

package rv_exec_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // widths
    typedef logic [31:0] xlen_t;      // data and pc
    typedef logic [4:0]  reg_idx_t;
    typedef logic [11:0] csr_addr_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // opcodes and fixed encodings
    localparam logic [6:0] OPC_LUI      = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC    = 7'b0010111;
    localparam logic [6:0] OPC_JAL      = 7'b1101111;
    localparam logic [6:0] OPC_JALR     = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH   = 7'b1100011;
    localparam logic [6:0] OPC_LOAD     = 7'b0000011;
    localparam logic [6:0] OPC_STORE    = 7'b0100011;
    localparam logic [6:0] OPC_OPIMM    = 7'b0010011;
    localparam logic [6:0] OPC_OP       = 7'b0110011;
    localparam logic [6:0] OPC_MISC_MEM = 7'b0001111;
    localparam logic [6:0] OPC_SYSTEM   = 7'b1110011;

    localparam xlen_t INSTR_ECALL  = 32'h0000_0073;
    localparam xlen_t INSTR_EBREAK = 32'h0010_0073;
    localparam xlen_t INSTR_MRET   = 32'h3020_0073;

    localparam csr_addr_t CSR_MSTATUS = 12'h300;
    localparam csr_addr_t CSR_MTVEC   = 12'h305;
    localparam csr_addr_t CSR_MEPC    = 12'h341;
    localparam csr_addr_t CSR_MCAUSE  = 12'h342;

    localparam xlen_t CAUSE_ECALL_M = 32'd11;
    localparam xlen_t RESET_MTVEC   = 32'h0000_0100;

    typedef enum logic [4:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR, ALU_SRL, ALU_SRA,
        ALU_OR, ALU_AND, ALU_LUI,
        ALU_EQ, ALU_NE, ALU_LT, ALU_GE, ALU_LTU, ALU_GEU  // branch compares
    } alu_op_e;

    typedef enum logic [3:0] {
        MEM_NONE, MEM_LB, MEM_LH, MEM_LW, MEM_LBU, MEM_LHU, MEM_SB, MEM_SH, MEM_SW
    } mem_op_e;

    typedef enum logic [1:0] {CSR_NONE, CSR_RW, CSR_RS} csr_op_e;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // bundles
    typedef struct packed {
        xlen_t instr;
        xlen_t pc;
    } inst_t;

    typedef struct packed {
        xlen_t     pc;
        xlen_t     imm;
        xlen_t     src1;
        xlen_t     src2;
        xlen_t     csr_data;      // old csr value, or trap target
        alu_op_e   alu_op;
        logic      src1_is_pc;
        logic      src2_is_imm;
        logic      is_jump;
        logic      is_branch;
        logic      is_fence_i;
        mem_op_e   mem_op;
        csr_op_e   csr_op;
        csr_addr_t csr_addr;
        reg_idx_t  rd;
        logic      rd_wen;
        logic      is_ecall;
        logic      is_mret;
        logic      is_ebreak;
        logic      is_illegal;
    } dec_bundle_t;

    typedef struct packed {
        reg_idx_t  rd;
        logic      rd_wen;
        xlen_t     result;
        logic      csr_wen;
        csr_addr_t csr_addr;
        xlen_t     csr_wdata;
        logic      is_ecall;
        xlen_t     trap_pc;
        mem_op_e   mem_op;
        xlen_t     mem_addr;
        xlen_t     store_data;
    } exu_out_t;

    typedef struct packed {
        xlen_t target;
    } redirect_t;

endpackage

`default_nettype wire

//--- rv_alu.sv
`timescale 1ns/1ns
`default_nettype none

module rv_alu import rv_exec_pkg::*; (
    input  wire alu_op_e alu_op,
    input  wire xlen_t   a,
    input  wire xlen_t   b,
    input  wire xlen_t   cmp_a,
    input  wire xlen_t   cmp_b,
    output xlen_t        result,
    output logic         cond
);

    logic [4:0] shamt;

    assign shamt = b[4:0];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // data result
    always_comb begin
        case (alu_op)
            ALU_ADD:  result = a + b;
            ALU_SUB:  result = a - b;
            ALU_SLL:  result = a << shamt;
            ALU_SLT:  result = {31'b0, $signed(a) < $signed(b)};
            ALU_SLTU: result = {31'b0, a < b};
            ALU_XOR:  result = a ^ b;
            ALU_SRL:  result = a >> shamt;
            ALU_SRA:  result = xlen_t'($signed(a) >>> shamt);
            ALU_OR:   result = a | b;
            ALU_AND:  result = a & b;
            ALU_LUI:  result = b;
            default:  result = a + b;  // branch target sum
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // compare result
    always_comb begin
        case (alu_op)
            ALU_EQ:   cond = (cmp_a == cmp_b);
            ALU_NE:   cond = (cmp_a != cmp_b);
            ALU_LT:   cond = ($signed(cmp_a) < $signed(cmp_b));
            ALU_GE:   cond = ($signed(cmp_a) >= $signed(cmp_b));
            ALU_LTU:  cond = (cmp_a < cmp_b);
            ALU_GEU:  cond = (cmp_a >= cmp_b);
            ALU_SLT,
            ALU_SLTU: cond = result[0];
            default:  cond = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

//--- rv_regfile.sv
`timescale 1ns/1ns
`default_nettype none

module rv_regfile import rv_exec_pkg::*; (
    input  wire           clk,
    input  wire           rst,
    input  wire reg_idx_t rs1,
    input  wire reg_idx_t rs2,
    output xlen_t         rs1_data,
    output xlen_t         rs2_data,
    input  wire           wen,
    input  wire reg_idx_t waddr,
    input  wire xlen_t    wdata
);

    xlen_t regs [1:31];  // x0 not stored

    function automatic xlen_t read_port(input reg_idx_t idx);
        if (idx == '0)
            return '0;
        if (wen && waddr == idx)
            return wdata;  // write-through
        return regs[idx];
    endfunction

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 1; i < 32; i++)
                regs[i] <= '0;
        end else if (wen && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    always_comb rs1_data = read_port(rs1);
    always_comb rs2_data = read_port(rs2);

    // stored value reads back unless overwritten again
    a_write_read: assert property (@(posedge clk) disable iff (rst)
        (wen && waddr != '0) |=>
            (rs1 != $past(waddr) || (wen && waddr == rs1) || rs1_data == $past(wdata)));

endmodule

`default_nettype wire

//--- rv_csr_file.sv
`timescale 1ns/1ns
`default_nettype none

module rv_csr_file import rv_exec_pkg::*; #(
    parameter xlen_t MTVEC_INIT = RESET_MTVEC
) (
    input  wire            clk,
    input  wire            rst,
    input  wire csr_addr_t raddr,
    output xlen_t          rdata,
    input  wire            wen,
    input  wire csr_addr_t waddr,
    input  wire xlen_t     wdata,
    input  wire            trap,
    input  wire xlen_t     trap_pc
);

    xlen_t mstatus, mtvec, mepc, mcause;
    xlen_t mstatus_d, mtvec_d, mepc_d, mcause_d;

    // next values, also the forwarded read source
    always_comb begin
        mstatus_d = mstatus;
        mtvec_d   = mtvec;
        mepc_d    = mepc;
        mcause_d  = mcause;
        if (trap) begin
            mepc_d   = trap_pc;
            mcause_d = CAUSE_ECALL_M;
        end else if (wen) begin
            case (waddr)
                CSR_MSTATUS: mstatus_d = wdata;
                CSR_MTVEC:   mtvec_d   = wdata;
                CSR_MEPC:    mepc_d    = wdata;
                CSR_MCAUSE:  mcause_d  = wdata;
                default: ;             // unknown csr, dropped
            endcase
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mstatus <= '0;
            mtvec   <= MTVEC_INIT;
            mepc    <= '0;
            mcause  <= '0;
        end else begin
            mstatus <= mstatus_d;
            mtvec   <= mtvec_d;
            mepc    <= mepc_d;
            mcause  <= mcause_d;
        end
    end

    always_comb begin
        case (raddr)
            CSR_MSTATUS: rdata = mstatus_d;
            CSR_MTVEC:   rdata = mtvec_d;
            CSR_MEPC:    rdata = mepc_d;
            CSR_MCAUSE:  rdata = mcause_d;
            default:     rdata = '0;
        endcase
    end

    // ecall never carries a csr write
    a_no_trap_write: assert property (@(posedge clk) disable iff (rst) !(trap && wen));

endmodule

`default_nettype wire

//--- rv_idu.sv
`timescale 1ns/1ns
`default_nettype none

module rv_idu import rv_exec_pkg::*; (
    input  wire inst_t inst,
    output reg_idx_t   rs1,
    output reg_idx_t   rs2,
    input  wire xlen_t rs1_data,
    input  wire xlen_t rs2_data,
    output csr_addr_t  csr_raddr,
    input  wire xlen_t csr_rdata,
    output dec_bundle_t dec
);

    xlen_t      instr;
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       is_ecall, is_mret;
    xlen_t      imm_i, imm_s, imm_b, imm_u, imm_j;

    function automatic alu_op_e arith_op(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? ALU_SUB : ALU_ADD;
            3'b001:  return ALU_SLL;
            3'b010:  return ALU_SLT;
            3'b011:  return ALU_SLTU;
            3'b100:  return ALU_XOR;
            3'b101:  return alt ? ALU_SRA : ALU_SRL;
            3'b110:  return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    assign instr  = inst.instr;
    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    assign is_ecall  = (instr == INSTR_ECALL);
    assign is_mret   = (instr == INSTR_MRET);
    assign csr_raddr = is_ecall ? CSR_MTVEC : is_mret ? CSR_MEPC : instr[31:20];

    always_comb begin
        dec          = '0;
        dec.pc       = inst.pc;
        dec.src1     = rs1_data;
        dec.src2     = rs2_data;
        dec.csr_data = csr_rdata;
        dec.csr_addr = instr[31:20];
        dec.rd       = instr[11:7];
        case (opcode)
            OPC_LUI:   {dec.alu_op, dec.src2_is_imm, dec.imm, dec.rd_wen} =
                           {ALU_LUI, 1'b1, imm_u, 1'b1};
            OPC_AUIPC: {dec.src1_is_pc, dec.src2_is_imm, dec.imm, dec.rd_wen} =
                           {2'b11, imm_u, 1'b1};
            OPC_JAL:   {dec.is_jump, dec.src1_is_pc, dec.src2_is_imm, dec.imm, dec.rd_wen} =
                           {3'b111, imm_j, 1'b1};
            OPC_JALR: begin
                {dec.is_jump, dec.src2_is_imm, dec.imm, dec.rd_wen} = {2'b11, imm_i, 1'b1};
                dec.is_illegal = (funct3 != 3'b000);
            end
            OPC_BRANCH: begin
                {dec.is_branch, dec.src1_is_pc, dec.src2_is_imm, dec.imm} = {3'b111, imm_b};
                case (funct3)
                    3'b000:  dec.alu_op = ALU_EQ;
                    3'b001:  dec.alu_op = ALU_NE;
                    3'b100:  dec.alu_op = ALU_LT;
                    3'b101:  dec.alu_op = ALU_GE;
                    3'b110:  dec.alu_op = ALU_LTU;
                    3'b111:  dec.alu_op = ALU_GEU;
                    default: {dec.is_branch, dec.is_illegal} = 2'b01;
                endcase
            end
            OPC_LOAD: begin
                {dec.src2_is_imm, dec.imm, dec.rd_wen} = {1'b1, imm_i, 1'b1};
                case (funct3)
                    3'b000:  dec.mem_op = MEM_LB;
                    3'b001:  dec.mem_op = MEM_LH;
                    3'b010:  dec.mem_op = MEM_LW;
                    3'b100:  dec.mem_op = MEM_LBU;
                    3'b101:  dec.mem_op = MEM_LHU;
                    default: dec.is_illegal = 1'b1;
                endcase
            end
            OPC_STORE: begin
                {dec.src2_is_imm, dec.imm} = {1'b1, imm_s};
                case (funct3)
                    3'b000:  dec.mem_op = MEM_SB;
                    3'b001:  dec.mem_op = MEM_SH;
                    3'b010:  dec.mem_op = MEM_SW;
                    default: dec.is_illegal = 1'b1;
                endcase
            end
            OPC_OPIMM: begin
                {dec.src2_is_imm, dec.imm, dec.rd_wen} = {1'b1, imm_i, 1'b1};
                dec.alu_op = arith_op(funct3, funct3 == 3'b101 && funct7[5]);
                dec.is_illegal = (funct3 == 3'b001 && funct7 != 7'b0) ||
                                 (funct3 == 3'b101 && (funct7 & 7'b1011111) != 7'b0);
            end
            OPC_OP: begin
                dec.rd_wen     = 1'b1;
                dec.alu_op     = arith_op(funct3, funct7[5]);
                dec.is_illegal = (funct7 != 7'b0) &&
                                 !(funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101));
            end
            OPC_MISC_MEM: begin            // plain fence is a nop
                dec.is_fence_i = (funct3 == 3'b001);
                dec.is_illegal = (funct3 != 3'b000 && funct3 != 3'b001);
            end
            OPC_SYSTEM: begin
                if (is_ecall)                    dec.is_ecall  = 1'b1;
                else if (instr == INSTR_EBREAK)  dec.is_ebreak = 1'b1;
                else if (is_mret)                dec.is_mret   = 1'b1;
                else if (funct3 == 3'b001)       {dec.csr_op, dec.rd_wen} = {CSR_RW, 1'b1};
                else if (funct3 == 3'b010)       {dec.csr_op, dec.rd_wen} = {CSR_RS, 1'b1};
                else                             dec.is_illegal = 1'b1;
            end
            default: dec.is_illegal = 1'b1;
        endcase
        if (dec.is_illegal)
            dec.rd_wen = 1'b0;
    end

endmodule

`default_nettype wire

//--- rv_exu.sv
`timescale 1ns/1ns
`default_nettype none

module rv_exu import rv_exec_pkg::*; (
    input  wire              clk,
    input  wire              rst,
    input  wire              inst_valid,
    input  wire dec_bundle_t dec,
    output logic             exu_valid,
    output exu_out_t         exu,
    output logic             redirect_valid,
    output redirect_t        redirect,
    output logic             fence_i,
    output logic             ebreak,
    output logic             illegal
);

    xlen_t    alu_a, alu_b, alu_res;
    logic     alu_cond;
    logic     take;
    xlen_t    target;
    exu_out_t exu_d;

    assign alu_a = dec.src1_is_pc  ? dec.pc  : dec.src1;
    assign alu_b = dec.src2_is_imm ? dec.imm : dec.src2;

    // compare always on the register operands
    rv_alu u_alu (
        .alu_op (dec.alu_op),
        .a      (alu_a),
        .b      (alu_b),
        .cmp_a  (dec.src1),
        .cmp_b  (dec.src2),
        .result (alu_res),
        .cond   (alu_cond)
    );

    assign take   = dec.is_ecall | dec.is_mret | dec.is_jump | (dec.is_branch & alu_cond);
    assign target = (dec.is_ecall | dec.is_mret) ? dec.csr_data :
                    dec.is_jump ? {alu_res[31:1], 1'b0} : alu_res;

    always_comb begin
        exu_d            = '0;
        exu_d.rd         = dec.rd;
        exu_d.rd_wen     = dec.rd_wen;
        exu_d.result     = dec.is_jump ? dec.pc + 32'd4 :
                           (dec.csr_op != CSR_NONE) ? dec.csr_data : alu_res;
        exu_d.csr_wen    = (dec.csr_op != CSR_NONE);
        exu_d.csr_addr   = dec.csr_addr;
        exu_d.csr_wdata  = (dec.csr_op == CSR_RS) ? (dec.src1 | dec.csr_data) : dec.src1;
        exu_d.is_ecall   = dec.is_ecall;
        exu_d.trap_pc    = dec.pc;
        exu_d.mem_op     = dec.mem_op;
        exu_d.mem_addr   = alu_res;    // base plus offset
        exu_d.store_data = dec.src2;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            exu_valid      <= 1'b0;
            exu            <= '0;
            redirect_valid <= 1'b0;
            redirect       <= '0;
            fence_i        <= 1'b0;
            ebreak         <= 1'b0;
            illegal        <= 1'b0;
        end else begin
            exu_valid      <= inst_valid;
            redirect_valid <= inst_valid & take;
            fence_i        <= inst_valid & dec.is_fence_i;
            ebreak         <= inst_valid & dec.is_ebreak;
            illegal        <= inst_valid & dec.is_illegal;
            if (inst_valid) begin
                exu             <= exu_d;
                redirect.target <= target;
            end
        end
    end

    // no redirect alongside a fence or a breakpoint
    a_redirect_valid: assert property (@(posedge clk) disable iff (rst)
        redirect_valid |-> exu_valid && !fence_i && !ebreak);

endmodule

`default_nettype wire

//--- rv_exec_core.sv
`timescale 1ns/1ns
`default_nettype none

module rv_exec_core import rv_exec_pkg::*; (
    input  wire            clk,
    input  wire            rst,
    input  wire            inst_valid,
    input  wire inst_t     inst,
    output wire            exu_valid,
    output wire exu_out_t  exu,
    output wire            redirect_valid,
    output wire redirect_t redirect,
    output wire            fence_i,
    output wire            ebreak,
    output wire            illegal
);

    reg_idx_t    rs1, rs2;
    xlen_t       rs1_data, rs2_data;
    csr_addr_t   csr_raddr;
    xlen_t       csr_rdata;
    dec_bundle_t dec;

    rv_idu u_idu (
        .inst, .rs1, .rs2, .rs1_data, .rs2_data, .csr_raddr, .csr_rdata, .dec
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // writeback from the registered execute result
    rv_regfile u_regfile (
        .clk, .rst, .rs1, .rs2, .rs1_data, .rs2_data,
        .wen   (exu_valid && exu.rd_wen),
        .waddr (exu.rd),
        .wdata (exu.result)
    );

    rv_csr_file u_csr_file (
        .clk, .rst,
        .raddr   (csr_raddr),
        .rdata   (csr_rdata),
        .wen     (exu_valid && exu.csr_wen),
        .waddr   (exu.csr_addr),
        .wdata   (exu.csr_wdata),
        .trap    (exu_valid && exu.is_ecall),
        .trap_pc (exu.trap_pc)
    );

    rv_exu u_exu (
        .clk, .rst, .inst_valid, .dec, .exu_valid, .exu,
        .redirect_valid, .redirect, .fence_i, .ebreak, .illegal
    );

endmodule

`default_nettype wire

//--- tb_rv_exec_core.sv
`timescale 1ns/1ns
`default_nettype none

module tb_rv_exec_core import rv_exec_pkg::*; ();

    localparam int MAX_CYCLES = 400;  // well above the directed sequence

    logic      clk, rst, inst_valid;
    inst_t     inst;
    logic      exu_valid, redirect_valid, fence_i, ebreak, illegal;
    exu_out_t  exu;
    redirect_t redirect;

    xlen_t xreg [32];                 // shadow register file
    xlen_t m_mtvec, m_mepc, m_mcause;
    xlen_t pc, last_pc;
    xlen_t seed = 32'headc;
    int    cycles = 0;
    string test_name;

    rv_exec_core UUT (
        .clk, .rst, .inst_valid, .inst, .exu_valid, .exu,
        .redirect_valid, .redirect, .fence_i, .ebreak, .illegal
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            abort_run();
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // encoders and isa rules
    function automatic xlen_t lcg();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic xlen_t sext12(input logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    function automatic xlen_t enc_i(input logic [11:0] imm, input reg_idx_t rs1,
                                    input logic [2:0] f3, input reg_idx_t rd,
                                    input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic xlen_t enc_r(input logic [6:0] f7, input reg_idx_t rs2,
                                    input reg_idx_t rs1, input logic [2:0] f3,
                                    input reg_idx_t rd);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic xlen_t enc_s(input logic [11:0] imm, input reg_idx_t rs2,
                                    input reg_idx_t rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], OPC_STORE};
    endfunction

    function automatic xlen_t enc_b(input logic [12:0] imm, input reg_idx_t rs2,
                                    input reg_idx_t rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
    endfunction

    function automatic xlen_t enc_j(input logic [20:0] imm, input reg_idx_t rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
    endfunction

    function automatic xlen_t isa_op(input logic [2:0] f3, input logic alt,
                                     input xlen_t a, input xlen_t b);
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return {31'b0, $signed(a) < $signed(b)};
            3'd3:    return {31'b0, a < b};
            3'd4:    return a ^ b;
            3'd5:    return alt ? xlen_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic br_taken(input logic [2:0] f3, input xlen_t a, input xlen_t b);
        case (f3)
            3'd0:    return a == b;
            3'd1:    return a != b;
            3'd4:    return $signed(a) < $signed(b);
            3'd5:    return $signed(a) >= $signed(b);
            3'd6:    return a < b;
            default: return a >= b;
        endcase
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // checks
    task automatic abort_run();
        $display("TESTS FAILED");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_word(input string what, input xlen_t exp, input xlen_t act);
        if (act !== exp) begin
            $display("CHECK FAILED %s %s: expected %h, actual %h", test_name, what, exp, act);
            abort_run();
        end
    endtask

    task automatic check_reg_idx(input string what, input reg_idx_t exp, input reg_idx_t act);
        if (act !== exp) begin
            $display("CHECK FAILED %s %s: expected %0d, actual %0d", test_name, what, exp, act);
            abort_run();
        end
    endtask

    task automatic check_csr_addr(input string what, input csr_addr_t exp,
                                  input csr_addr_t act);
        if (act !== exp) begin
            $display("CHECK FAILED %s %s: expected %h, actual %h", test_name, what, exp, act);
            abort_run();
        end
    endtask

    task automatic check_flag(input string what, input logic exp, input logic act);
        if (act !== exp) begin
            $display("CHECK FAILED %s %s: expected %b, actual %b", test_name, what, exp, act);
            abort_run();
        end
    endtask

    task automatic check_mem_op(input string what, input mem_op_e exp, input mem_op_e act);
        if (act !== exp) begin
            $display("CHECK FAILED %s %s: expected %0d, actual %0d", test_name, what, exp, act);
            abort_run();
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // drive helpers
    task automatic step(input xlen_t instr);
        inst_valid = 1'b1;
        inst.instr = instr;
        inst.pc    = pc;
        @(negedge clk);            // result registered at the edge before
        last_pc = pc;
        pc      = pc + 32'd4;
        check_flag("exu_valid", 1'b1, exu_valid);
    endtask

    task automatic idle();
        inst_valid = 1'b0;
        @(negedge clk);
        check_flag("exu_valid idle", 1'b0, exu_valid);
    endtask

    task automatic check_wb(input reg_idx_t rd, input xlen_t exp);
        check_reg_idx("rd", rd, exu.rd);
        check_flag("rd_wen", 1'b1, exu.rd_wen);
        check_word("result", exp, exu.result);
        if (rd != 0)
            xreg[rd] = exp;
    endtask

    task automatic check_csr_write(input csr_addr_t addr, input xlen_t exp);
        check_flag("csr_wen", 1'b1, exu.csr_wen);
        check_csr_addr("csr_addr", addr, exu.csr_addr);
        check_word("csr_wdata", exp, exu.csr_wdata);
    endtask

    task automatic load_reg(input reg_idx_t rd, input xlen_t value);
        logic [19:0] hi;
        hi = value[31:12] + {19'b0, value[11]};  // addi sign-extends the low part
        step({hi, rd, OPC_LUI});
        check_wb(rd, {hi, 12'b0});
        step(enc_i(value[11:0], rd, 3'd0, rd, OPC_OPIMM));
        check_wb(rd, value);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // directed tests
    task automatic test_alu();
        logic [2:0]  f3;
        logic        alt;
        logic [11:0] imm;
        reg_idx_t    rs1;
        test_name = "alu";
        load_reg(5'd1, lcg());
        load_reg(5'd2, lcg());
        for (int i = 0; i < 10; i++) begin  // 8 and 9 are sub and sra
            f3  = (i < 8) ? 3'(i) : (i == 8 ? 3'd0 : 3'd5);
            alt = (i >= 8);
            step(enc_r({1'b0, alt, 5'b0}, 5'd2, 5'd1, f3, 5'(3 + i)));
            check_wb(5'(3 + i), isa_op(f3, alt, xreg[1], xreg[2]));
        end
        rs1 = 5'd3;
        for (int i = 0; i < 9; i++) begin  // chained through forwarding
            f3  = (i < 8) ? 3'(i) : 3'd5;
            alt = (i == 8);
            imm = lcg();
            if (f3 == 3'd1 || f3 == 3'd5)
                imm = {1'b0, alt, 5'b0, imm[4:0]};
            step(enc_i(imm, rs1, f3, 5'(13 + i), OPC_OPIMM));
            check_wb(5'(13 + i), isa_op(f3, alt, xreg[rs1], sext12(imm)));
            rs1 = 5'(13 + i);
        end
        idle();
    endtask

    task automatic test_branch();
        logic [2:0]  f3s [6] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
        logic [12:0] imm;
        logic [20:0] jimm;
        logic        taken;
        reg_idx_t    rs2;
        xlen_t       target;
        test_name = "branch";
        for (int j = 0; j < 2; j++) begin
            rs2 = j ? 5'd1 : 5'd2;          // second pass compares equal operands
            for (int i = 0; i < 6; i++) begin
                imm   = {lcg(), 1'b0};
                taken = br_taken(f3s[i], xreg[1], xreg[rs2]);
                step(enc_b(imm, rs2, 5'd1, f3s[i]));
                check_flag("redirect_valid", taken, redirect_valid);
                if (taken)
                    check_word("target", last_pc + {{19{imm[12]}}, imm}, redirect.target);
                check_flag("rd_wen", 1'b0, exu.rd_wen);
            end
        end
        test_name = "jump";
        jimm = {lcg(), 1'b0};
        step(enc_j(jimm, 5'd5));
        check_flag("redirect_valid", 1'b1, redirect_valid);
        check_word("target", last_pc + {{11{jimm[20]}}, jimm}, redirect.target);
        check_wb(5'd5, last_pc + 32'd4);
        imm    = lcg();
        target = (xreg[1] + sext12(imm[11:0])) & ~32'd1;
        step(enc_i(imm[11:0], 5'd1, 3'd0, 5'd6, OPC_JALR));
        check_flag("redirect_valid", 1'b1, redirect_valid);
        check_word("target", target, redirect.target);
        check_wb(5'd6, last_pc + 32'd4);
        idle();
    endtask

    task automatic test_csr();
        test_name = "csr";
        step(enc_i(CSR_MTVEC, 5'd1, 3'd1, 5'd7, OPC_SYSTEM));  // csrrw
        check_wb(5'd7, m_mtvec);
        check_csr_write(CSR_MTVEC, xreg[1]);
        m_mtvec = xreg[1];
        step(enc_i(CSR_MTVEC, 5'd2, 3'd2, 5'd8, OPC_SYSTEM));  // csrrs
        check_wb(5'd8, m_mtvec);
        check_csr_write(CSR_MTVEC, m_mtvec | xreg[2]);
        m_mtvec = m_mtvec | xreg[2];
        step(enc_i(CSR_MTVEC, 5'd0, 3'd2, 5'd9, OPC_SYSTEM));
        check_wb(5'd9, m_mtvec);
        check_csr_write(CSR_MTVEC, m_mtvec);
        test_name = "ecall";
        step(enc_i(12'h000, 5'd0, 3'd0, 5'd0, OPC_SYSTEM));
        check_flag("redirect_valid", 1'b1, redirect_valid);
        check_word("target", m_mtvec, redirect.target);
        check_flag("rd_wen", 1'b0, exu.rd_wen);
        check_flag("is_ecall", 1'b1, exu.is_ecall);
        check_word("trap_pc", last_pc, exu.trap_pc);
        check_flag("csr_wen", 1'b0, exu.csr_wen);
        m_mepc   = last_pc;
        m_mcause = 32'd11;
        step(enc_i(CSR_MEPC, 5'd0, 3'd2, 5'd10, OPC_SYSTEM));
        check_wb(5'd10, m_mepc);
        check_csr_write(CSR_MEPC, m_mepc);
        step(enc_i(CSR_MCAUSE, 5'd0, 3'd2, 5'd11, OPC_SYSTEM));
        check_wb(5'd11, m_mcause);
        test_name = "mret";
        step(enc_i(12'h302, 5'd0, 3'd0, 5'd0, OPC_SYSTEM));
        check_flag("redirect_valid", 1'b1, redirect_valid);
        check_word("target", m_mepc, redirect.target);
        idle();
    endtask

    task automatic test_mem();
        logic [2:0] lf3 [5] = '{3'd0, 3'd1, 3'd2, 3'd4, 3'd5};
        mem_op_e    lops [5] = '{MEM_LB, MEM_LH, MEM_LW, MEM_LBU, MEM_LHU};
        mem_op_e    sops [3] = '{MEM_SB, MEM_SH, MEM_SW};
        xlen_t      off;
        test_name = "load";
        for (int i = 0; i < 5; i++) begin
            off = lcg();
            step(enc_i(off[11:0], 5'd1, lf3[i], 5'd31, OPC_LOAD));  // x31 left unused
            check_mem_op("mem_op", lops[i], exu.mem_op);
            check_word("mem_addr", xreg[1] + sext12(off[11:0]), exu.mem_addr);
        end
        test_name = "store";
        for (int i = 0; i < 3; i++) begin
            off = lcg();
            step(enc_s(off[11:0], 5'd2, 5'd1, 3'(i)));
            check_mem_op("mem_op", sops[i], exu.mem_op);
            check_word("mem_addr", xreg[1] + sext12(off[11:0]), exu.mem_addr);
            check_word("store_data", xreg[2], exu.store_data);
            check_flag("rd_wen", 1'b0, exu.rd_wen);
        end
        idle();
    endtask

    task automatic check_sys_flags(input logic f, input logic e, input logic il);
        check_flag("fence_i", f, fence_i);
        check_flag("ebreak", e, ebreak);
        check_flag("illegal", il, illegal);
        check_flag("redirect_valid", 1'b0, redirect_valid);
    endtask

    task automatic test_sys();
        test_name = "system";
        step(enc_i(12'h000, 5'd0, 3'd1, 5'd0, OPC_MISC_MEM));  // fence.i
        check_sys_flags(1'b1, 1'b0, 1'b0);
        step(enc_i(12'h001, 5'd0, 3'd0, 5'd0, OPC_SYSTEM));    // ebreak
        check_sys_flags(1'b0, 1'b1, 1'b0);
        step(32'hffff_ffff);
        check_sys_flags(1'b0, 1'b0, 1'b1);
        check_flag("rd_wen", 1'b0, exu.rd_wen);
        test_name = "x0";
        step(enc_i(12'h123, 5'd1, 3'd0, 5'd0, OPC_OPIMM));     // write to x0
        check_sys_flags(1'b0, 1'b0, 1'b0);
        step(enc_r(7'b0, 5'd0, 5'd0, 3'd0, 5'd20));
        check_wb(5'd20, 32'd0);
        idle();
    endtask

    initial begin
        clk        = 1'b0;
        rst        = 1'b1;
        inst_valid = 1'b0;
        inst       = '0;
        for (int i = 0; i < 32; i++)
            xreg[i] = '0;
        m_mtvec  = RESET_MTVEC;
        m_mepc   = '0;
        m_mcause = '0;
        pc       = 32'h0000_1000;
        last_pc  = pc;
        repeat (3) @(negedge clk);
        rst = 1'b0;
        test_name = "reset";
        check_flag("exu_valid", 1'b0, exu_valid);
        check_sys_flags(1'b0, 1'b0, 1'b0);
        test_alu();
        test_branch();
        test_csr();
        test_mem();
        test_sys();
        $display("TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- compile.f
rv_exec_pkg.sv
rv_alu.sv
rv_regfile.sv
rv_csr_file.sv
rv_idu.sv
rv_exu.sv
rv_exec_core.sv
tb_rv_exec_core.sv
